// ==== logic/grom_defines.svh ====
`ifndef GROM_DEFINES_SVH
`define GROM_DEFINES_SVH

// populated slots, 1 to 8
`define GROM_COUNT 8

// bytes in one 2 KiB page
`define GROM_PAGE_DEPTH 2048

// slot id, address inside the 8 KiB window, offset inside a page
`define GROM_ID_W 3
`define GROM_ADDR_W 13
`define GROM_OFS_W 11

// slot id joined to page offset
`define GROM_IDX_W (`GROM_ID_W + `GROM_OFS_W)

`endif

// ==== logic/grom_pkg.sv ====
`default_nettype none

`include "grom_defines.svh"

package grom_pkg;

   // encoded as {m, mo}
   typedef enum logic [1:0] {
      GOP_WRITE_DATA = 2'b00,
      GOP_WRITE_ADDR = 2'b01,
      GOP_READ_DATA  = 2'b10,
      GOP_READ_ADDR  = 2'b11
   } grom_op_e;

   typedef enum logic [1:0] {
      PORT_IDLE  = 2'b00,
      PORT_FETCH = 2'b01,   // arrays read, counter steps
      PORT_LATCH = 2'b10    // merged byte captured
   } grom_port_state_e;

   // prefetch from the CPU side
   typedef struct packed {
      logic                   valid;
      logic [`GROM_IDX_W-1:0] idx;
   } grom_fetch_req_t;

   // host access, page select 3 is unmapped
   typedef struct packed {
      logic                   rd;
      logic                   wr;
      logic [1:0]             page;
      logic [`GROM_IDX_W-1:0] idx;
      logic [7:0]             wdata;
   } grom_host_req_t;

   typedef struct packed {
      logic [7:0] page2;
      logic [7:0] page1;
      logic [7:0] page0;
   } grom_page_bytes_t;

endpackage

`default_nettype wire

// ==== logic/grom_port.sv ====
`default_nettype none

`include "grom_defines.svh"

module grom_port (
   input  logic                      clk,
   input  logic                      rst_n_i,
   input  logic                      gs_i,
   input  logic                      m_i,
   input  logic                      mo_i,
   input  logic [7:0]                d_i,
   output logic [7:0]                q_o,
   output logic                      gready_o,
   output logic [15:0]               debug_addr_o,
   output grom_pkg::grom_fetch_req_t fetch_req_o,
   output logic [2:0]                page_mask_o,
   input  logic [7:0]                fetch_byte_i
);
   import grom_pkg::*;

   grom_port_state_e        state_q;
   grom_op_e                op;
   logic [`GROM_ID_W-1:0]   grom_id_q;
   logic [`GROM_ADDR_W-1:0] addr_q;
   logic                    addr_toggle_q;   // first byte of pair seen
   logic [7:0]              out_byte_q;      // prefetched byte
   logic                    slot_present;
   logic [1:0]              addr_top;

   assign op           = grom_op_e'({m_i, mo_i});
   assign gready_o     = (state_q == PORT_IDLE);
   assign debug_addr_o = {grom_id_q, addr_q};
   assign slot_present = (grom_id_q < `GROM_COUNT);
   assign addr_top     = addr_q[`GROM_ADDR_W-1 -: 2];

   assign fetch_req_o.valid = (state_q == PORT_FETCH);
   assign fetch_req_o.idx   = {grom_id_q, addr_q[`GROM_OFS_W-1:0]};

   // which pages answer at this address
   always_comb begin
      page_mask_o = 3'b000;
      if (slot_present) begin
         page_mask_o[0] = (addr_top == 2'b00);
         page_mask_o[1] = addr_top[0];
         page_mask_o[2] = addr_top[1];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q       <= PORT_IDLE;
         grom_id_q     <= '0;
         addr_q        <= '0;
         addr_toggle_q <= 1'b0;
         out_byte_q    <= 8'h00;
         q_o           <= 8'h00;
      end else begin
         case (state_q)
            PORT_IDLE: begin
               if (gs_i) begin
                  case (op)
                     GOP_READ_DATA: begin
                        q_o           <= out_byte_q;
                        addr_toggle_q <= 1'b0;
                        state_q       <= PORT_FETCH;
                     end
                     GOP_READ_ADDR: begin
                        // high byte out, low byte moves up
                        q_o                         <= debug_addr_o[15:8];
                        {grom_id_q, addr_q[12:8]}   <= debug_addr_o[7:0];
                        addr_toggle_q               <= 1'b0;
                     end
                     GOP_WRITE_ADDR: begin
                        {grom_id_q, addr_q} <= {debug_addr_o[7:0], d_i};
                        addr_toggle_q       <= ~addr_toggle_q;
                        if (addr_toggle_q) begin
                           state_q <= PORT_FETCH;   // pair complete
                        end
                     end
                     default: begin
                        // rom, data writes dropped
                     end
                  endcase
               end
            end
            PORT_FETCH: begin
               addr_q  <= addr_q + 1'b1;
               state_q <= PORT_LATCH;
            end
            PORT_LATCH: begin
               out_byte_q <= fetch_byte_i;   // merged one cycle after fetch
               state_q    <= PORT_IDLE;
            end
            default: begin
               state_q <= PORT_IDLE;
            end
         endcase
      end
   end

   // prefetch always takes exactly two busy cycles
   assert property (@(posedge clk) disable iff (!rst_n_i)
      (state_q == PORT_FETCH) |=> (state_q == PORT_LATCH))
      else $error("grom_port: FETCH not followed by LATCH");

   // a fetch only follows a strobe taken while ready
   assert property (@(posedge clk) disable iff (!rst_n_i)
      fetch_req_o.valid |-> $past(gs_i && gready_o))
      else $error("grom_port: fetch request without accepted strobe");

endmodule

`default_nettype wire

// ==== logic/grom_host.sv ====
`default_nettype none

`include "grom_defines.svh"

module grom_host (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic [15:0]                wb_adr_i,
   input  logic [7:0]                 wb_dat_i,
   output logic [7:0]                 wb_dat_o,
   input  logic                       wb_we_i,
   input  logic                       wb_sel_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_cyc_i,
   output logic                       wb_ack_o,
   output grom_pkg::grom_host_req_t   host_req_o,
   input  logic                       host_grant_i,
   input  grom_pkg::grom_page_bytes_t page_bytes_i
);
   import grom_pkg::*;

   logic                   bus_access;
   logic                   rd_done_q;   // read data sits in page regs
   logic [1:0]             page_sel;
   logic [`GROM_ID_W-1:0]  slot;
   logic [`GROM_OFS_W-1:0] ofs;

   assign bus_access = wb_cyc_i && wb_stb_i;

   // address fields: slot, page, offset
   assign slot     = wb_adr_i[15 -: `GROM_ID_W];
   assign page_sel = wb_adr_i[`GROM_OFS_W +: 2];
   assign ofs      = wb_adr_i[`GROM_OFS_W-1:0];

   assign host_req_o.rd    = bus_access && !wb_we_i && !rd_done_q;
   assign host_req_o.wr    = bus_access && wb_we_i && wb_sel_i;
   assign host_req_o.page  = page_sel;
   assign host_req_o.idx   = {slot, ofs};
   assign host_req_o.wdata = wb_dat_i;

   // writes ack at once, reads once the store has read
   assign wb_ack_o = (bus_access && wb_we_i) || rd_done_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_done_q <= 1'b0;
      end else begin
         rd_done_q <= host_req_o.rd && host_grant_i;
      end
   end

   always_comb begin
      case (page_sel)
         2'd0:    wb_dat_o = page_bytes_i.page0;
         2'd1:    wb_dat_o = page_bytes_i.page1;
         2'd2:    wb_dat_o = page_bytes_i.page2;
         default: wb_dat_o = 8'h00;   // unmapped page
      endcase
   end

   assert property (@(posedge clk) disable iff (!rst_n_i)
      (wb_ack_o && !wb_we_i) |=> !(wb_ack_o && !wb_we_i))
      else $error("grom_host: read acknowledge held two cycles");

endmodule

`default_nettype wire

// ==== logic/grom_store.sv ====
`default_nettype none

`include "grom_defines.svh"

module grom_store (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  grom_pkg::grom_fetch_req_t  fetch_req_i,
   input  logic [2:0]                 page_mask_i,
   output logic [7:0]                 fetch_byte_o,
   input  grom_pkg::grom_host_req_t   host_req_i,
   output logic                       host_grant_o,
   output grom_pkg::grom_page_bytes_t page_bytes_o
);
   import grom_pkg::*;

   localparam int unsigned MEM_DEPTH = `GROM_COUNT * `GROM_PAGE_DEPTH;

   logic                   rd_en;
   logic [`GROM_IDX_W-1:0] rd_idx;
   logic                   rd_slot_ok;
   logic                   wr_slot_ok;
   logic [2:0]             mask_q;   // pages of the last fetch

   // fetch wins, host read waits
   assign host_grant_o = host_req_i.rd && !fetch_req_i.valid;
   assign rd_en        = fetch_req_i.valid || host_grant_o;
   assign rd_idx       = fetch_req_i.valid ? fetch_req_i.idx : host_req_i.idx;

   // unpopulated slots read as zero
   assign rd_slot_ok = (rd_idx[`GROM_IDX_W-1 -: `GROM_ID_W] < `GROM_COUNT);
   assign wr_slot_ok = (host_req_i.idx[`GROM_IDX_W-1 -: `GROM_ID_W] < `GROM_COUNT);

   for (genvar p = 0; p < 3; p++) begin : g_page
      logic [7:0] mem [MEM_DEPTH];
      logic [7:0] byte_q;
      logic       wr_hit;

      assign wr_hit = host_req_i.wr && wr_slot_ok && (host_req_i.page == p);

      always_ff @(posedge clk) begin
         if (wr_hit) begin
            mem[host_req_i.idx] <= host_req_i.wdata;
         end
         if (rd_en) begin
            byte_q <= rd_slot_ok ? mem[rd_idx] : 8'h00;
         end
      end
   end

   assign page_bytes_o.page0 = g_page[0].byte_q;
   assign page_bytes_o.page1 = g_page[1].byte_q;
   assign page_bytes_o.page2 = g_page[2].byte_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mask_q <= 3'b000;
      end else if (fetch_req_i.valid) begin
         mask_q <= page_mask_i;
      end
   end

   // overlapping pages OR together
   always_comb begin
      fetch_byte_o = 8'h00;
      if (mask_q[0]) begin
         fetch_byte_o = fetch_byte_o | page_bytes_o.page0;
      end
      if (mask_q[1]) begin
         fetch_byte_o = fetch_byte_o | page_bytes_o.page1;
      end
      if (mask_q[2]) begin
         fetch_byte_o = fetch_byte_o | page_bytes_o.page2;
      end
   end

   // a read held off by a fetch goes through one cycle later
   assert property (@(posedge clk) disable iff (!rst_n_i)
      (host_req_i.rd && fetch_req_i.valid) |=> host_grant_o)
      else $error("grom_store: held host read not granted after fetch");

endmodule

`default_nettype wire

// ==== logic/grom_top.sv ====
`default_nettype none

module grom_top (
   input  logic        clk,
   input  logic        rst_n_i,
   // CPU side
   input  logic        gs_i,
   input  logic        m_i,
   input  logic        mo_i,
   input  logic [7:0]  d_i,
   output logic [7:0]  q_o,
   output logic        gready_o,
   output logic [15:0] debug_addr_o,
   // host side Wishbone
   input  logic [15:0] wb_adr_i,
   input  logic [7:0]  wb_dat_i,
   output logic [7:0]  wb_dat_o,
   input  logic        wb_we_i,
   input  logic        wb_sel_i,
   input  logic        wb_stb_i,
   input  logic        wb_cyc_i,
   output logic        wb_ack_o
);
   import grom_pkg::*;

   grom_fetch_req_t  fetch_req;
   logic [2:0]       page_mask;
   logic [7:0]       fetch_byte;
   grom_host_req_t   host_req;
   logic             host_grant;
   grom_page_bytes_t page_bytes;

   grom_port u_port (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .gs_i         (gs_i),
      .m_i          (m_i),
      .mo_i         (mo_i),
      .d_i          (d_i),
      .q_o          (q_o),
      .gready_o     (gready_o),
      .debug_addr_o (debug_addr_o),
      .fetch_req_o  (fetch_req),
      .page_mask_o  (page_mask),
      .fetch_byte_i (fetch_byte)
   );

   grom_host u_host (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_we_i      (wb_we_i),
      .wb_sel_i     (wb_sel_i),
      .wb_stb_i     (wb_stb_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_ack_o     (wb_ack_o),
      .host_req_o   (host_req),
      .host_grant_i (host_grant),
      .page_bytes_i (page_bytes)
   );

   grom_store u_store (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fetch_req_i  (fetch_req),
      .page_mask_i  (page_mask),
      .fetch_byte_o (fetch_byte),
      .host_req_i   (host_req),
      .host_grant_o (host_grant),
      .page_bytes_o (page_bytes)
   );

endmodule

`default_nettype wire

// ==== bench/grom_tb.sv ====
`default_nettype none

`include "grom_defines.svh"

module grom_tb;

   localparam int N_RAND  = 12;   // wishbone writes in readback test
   localparam int N_FILL  = 48;   // 3 pages x 16 offsets
   localparam int N_HOST  = 6;
   localparam int WB_CYC  = 5;
   localparam int CPU_CYC = 6;
   localparam int PLANNED_CYCLES = 8 + N_RAND * 2 * WB_CYC + N_FILL * WB_CYC
      + (3 * 10 + 11 + 12) * CPU_CYC + N_HOST * (WB_CYC + 8);
   localparam int TIMEOUT_CYCLES = 4 * PLANNED_CYCLES;
   localparam int MEM_DEPTH = `GROM_COUNT * `GROM_PAGE_DEPTH;

   logic        clk = 1'b0;
   logic        rst_n_i;
   logic        gs_i;
   logic        m_i;
   logic        mo_i;
   logic [7:0]  d_i;
   logic [7:0]  q_o;
   logic        gready_o;
   logic [15:0] debug_addr_o;
   logic [15:0] wb_adr_i;
   logic [7:0]  wb_dat_i;
   logic [7:0]  wb_dat_o;
   logic        wb_we_i;
   logic        wb_sel_i;
   logic        wb_stb_i;
   logic        wb_cyc_i;
   logic        wb_ack_o;

   logic [31:0] lfsr_q = 32'h916cb8b5;
   logic [7:0]  model_mem [3][MEM_DEPTH];
   logic [15:0] model_addr;   // slot id joined to counter
   logic [7:0]  model_latch;
   logic        model_toggle;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_err0 = 0;
   int          cycle_cnt = 0;

   grom_top UUT (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .gs_i         (gs_i),
      .m_i          (m_i),
      .mo_i         (mo_i),
      .d_i          (d_i),
      .q_o          (q_o),
      .gready_o     (gready_o),
      .debug_addr_o (debug_addr_o),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_we_i      (wb_we_i),
      .wb_sel_i     (wb_sel_i),
      .wb_stb_i     (wb_stb_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_ack_o     (wb_ack_o)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST FAIL");
         $finish;
      end
   end

   // galois lfsr, one step per bit
   function automatic logic [31:0] take_bits(input int unsigned n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   function automatic logic [7:0] model_read(input logic [15:0] adr);
      logic [1:0] page;
      page = adr[12:11];
      if (page == 2'd3 || adr[15:13] >= `GROM_COUNT) begin
         return 8'h00;
      end
      return model_mem[page][{adr[15:13], adr[10:0]}];
   endfunction

   // pages selected by the two top counter bits, OR merged
   function automatic logic [7:0] model_fetch(input logic [15:0] a);
      logic [13:0] idx;
      logic [7:0]  r;
      idx = {a[15:13], a[10:0]};
      r = 8'h00;
      if (a[15:13] >= `GROM_COUNT) begin
         return 8'h00;
      end
      if (a[12:11] == 2'b00) r = r | model_mem[0][idx];
      if (a[11]) r = r | model_mem[1][idx];
      if (a[12]) r = r | model_mem[2][idx];
      return r;
   endfunction

   function automatic logic [15:0] next_addr(input logic [15:0] a);
      return {a[15:13], a[12:0] + 13'd1};   // counter wraps inside the slot
   endfunction

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_ready(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s finished with %0d errors", tests, name, errors - test_err0);
      test_err0 = errors;
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= 1'b1;
      wb_sel_i <= 1'b1;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      @(negedge clk);
      check_ready("wb_ack_o", wb_ack_o, 1'b1);   // write ack is combinational
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
      if (adr[12:11] != 2'd3 && adr[15:13] < `GROM_COUNT) begin
         model_mem[adr[12:11]][{adr[15:13], adr[10:0]}] = dat;
      end
   endtask

   task automatic wb_read(input logic [15:0] adr);
      int         waited;
      logic [7:0] exp;
      exp = model_read(adr);
      @(posedge clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= 1'b0;
      wb_adr_i <= adr;
      waited = 0;
      @(negedge clk);
      while (!wb_ack_o && waited < 8) begin
         waited++;
         @(negedge clk);
      end
      if (!wb_ack_o) begin
         report_failure("Wishbone read got no acknowledge within 8 cycles");
      end else begin
         check_byte("wb_dat_o", wb_dat_o, exp);
      end
      @(posedge clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      @(negedge clk);
      if (wb_ack_o) begin
         report_failure("Wishbone read acknowledge lasted more than one cycle");
      end
   endtask

   // one gs pulse once the port is ready, returns at the following negedge
   task automatic cpu_strobe(input logic m, input logic mo, input logic [7:0] d);
      @(negedge clk);
      while (!gready_o) begin
         @(negedge clk);
      end
      @(posedge clk);
      gs_i <= 1'b1;
      m_i  <= m;
      mo_i <= mo;
      d_i  <= d;
      @(posedge clk);
      gs_i <= 1'b0;
      @(negedge clk);
   endtask

   task automatic count_busy(input int exp);
      int busy;
      busy = 0;
      while (!gready_o && busy < 8) begin
         busy++;
         @(negedge clk);
      end
      if (busy != exp) begin
         report_failure($sformatf("gready_o was low for %0d cycles instead of %0d", busy, exp));
      end
   endtask

   task automatic cpu_addr_write(input logic [7:0] d);
      cpu_strobe(1'b0, 1'b1, d);
      model_addr = {model_addr[7:0], d};
      if (model_toggle) begin
         count_busy(2);   // second byte of the pair prefetches
         model_latch = model_fetch(model_addr);
         model_addr  = next_addr(model_addr);
      end else begin
         count_busy(0);
      end
      model_toggle = !model_toggle;
   endtask

   task automatic set_address(input logic [15:0] a);
      cpu_addr_write(a[15:8]);
      cpu_addr_write(a[7:0]);
      check_addr("debug_addr_o", debug_addr_o, next_addr(a));
   endtask

   task automatic cpu_read_data();
      cpu_strobe(1'b1, 1'b0, 8'h00);
      check_byte("q_o", q_o, model_latch);
      count_busy(2);
      model_latch  = model_fetch(model_addr);
      model_addr   = next_addr(model_addr);
      model_toggle = 1'b0;
   endtask

   task automatic cpu_addr_read();
      cpu_strobe(1'b1, 1'b1, 8'h00);
      check_byte("q_o", q_o, model_addr[15:8]);
      check_ready("gready_o", gready_o, 1'b1);
      model_addr   = {model_addr[7:0], model_addr[7:0]};
      model_toggle = 1'b0;
      check_addr("debug_addr_o", debug_addr_o, model_addr);
   endtask

   task automatic cpu_data_write(input logic [7:0] d);
      cpu_strobe(1'b0, 1'b0, d);
      check_ready("gready_o", gready_o, 1'b1);
      check_addr("debug_addr_o", debug_addr_o, model_addr);
   endtask

   initial begin
      logic [15:0] adrs [N_RAND];
      logic [15:0] host_adrs [N_HOST];
      int          gaps [N_HOST];
      logic [2:0]  slot;
      rst_n_i  = 1'b0;
      gs_i     = 1'b0;
      m_i      = 1'b0;
      mo_i     = 1'b0;
      d_i      = 8'h00;
      wb_adr_i = 16'h0000;
      wb_dat_i = 8'h00;
      wb_we_i  = 1'b0;
      wb_sel_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      model_addr   = 16'h0000;
      model_latch  = 8'h00;
      model_toggle = 1'b0;
      repeat (8) @(posedge clk);
      rst_n_i <= 1'b1;

      @(negedge clk);
      check_byte("q_o", q_o, 8'h00);
      check_ready("gready_o", gready_o, 1'b1);
      check_ready("wb_ack_o", wb_ack_o, 1'b0);
      check_addr("debug_addr_o", debug_addr_o, 16'h0000);
      finish_test("reset state");

      // page 3 entries reuse the page 2 index before them
      for (int i = 0; i < N_RAND; i++) begin
         adrs[i] = take_bits(16);
         adrs[i][12:11] = i % 4;
         if (i % 4 == 3) begin
            adrs[i][15:13] = adrs[i-1][15:13];
            adrs[i][10:0]  = adrs[i-1][10:0];
         end
         wb_write(adrs[i], take_bits(8));
      end
      for (int i = 0; i < N_RAND; i++) begin
         wb_read(adrs[i]);
      end
      finish_test("wishbone readback");

      // fill offsets 7f8..7ff and 000..007 of every page in one slot
      slot = take_bits(3) % `GROM_COUNT;
      for (int p = 0; p < 3; p++) begin
         for (int k = 0; k < 16; k++) begin
            wb_write({slot, p[1:0], 11'h7F8 + k[10:0]}, take_bits(8));
         end
      end

      for (int b = 1; b <= 3; b++) begin
         set_address({slot, b[1:0], 11'h000} - 16'd4);
         repeat (8) cpu_read_data();
         check_addr("debug_addr_o", debug_addr_o, model_addr);
      end
      finish_test("sequential data reads");

      set_address({slot, 13'h07FD});
      cpu_addr_read();
      cpu_addr_read();
      cpu_data_write(take_bits(8));
      set_address({slot, 13'h0FFE});
      cpu_data_write(take_bits(8));
      repeat (3) cpu_read_data();
      finish_test("address reads and data writes");

      for (int i = 0; i < N_HOST; i++) begin
         host_adrs[i] = {slot, 2'(take_bits(2) % 3), 11'h7F8 + 11'(take_bits(4))};
         gaps[i] = take_bits(3);
      end
      set_address({slot, 13'h17FA});
      fork
         begin
            repeat (10) cpu_read_data();
         end
         begin
            for (int i = 0; i < N_HOST; i++) begin
               repeat (gaps[i]) @(posedge clk);
               wb_read(host_adrs[i]);
            end
         end
      join
      finish_test("host reads during CPU reads");

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/grom_pkg.sv
logic/grom_port.sv
logic/grom_host.sv
logic/grom_store.sv
logic/grom_top.sv
bench/grom_tb.sv

// ==== Bender.yml ====
package:
  name: grom

sources:
  - include_dirs:
      - logic
    files:
      - logic/grom_pkg.sv
      - logic/grom_port.sv
      - logic/grom_host.sv
      - logic/grom_store.sv
      - logic/grom_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/grom_tb.sv
